// ==== verilog/clk_rst_pkg.sv ====
// Widths, register map and reset values for the clock/reset generator; all domains share one map
package clk_rst_pkg;

  // Configuration bus
  localparam int CFG_ADDR_W = 2;
  localparam int CFG_DATA_W = 32;

  // Field widths inside the data word
  localparam int DIV_W    = 8;   // Divider, 0 behaves as 1
  localparam int SETTLE_W = 8;   // Enable pulses before lock

  // Register map
  localparam logic [CFG_ADDR_W-1:0] ADDR_STATUS = 2'd0;  // Bit 0 is lock, read only
  localparam logic [CFG_ADDR_W-1:0] ADDR_DIV    = 2'd1;
  localparam logic [CFG_ADDR_W-1:0] ADDR_SETTLE = 2'd2;
  localparam logic [CFG_ADDR_W-1:0] ADDR_SPARE  = 2'd3;  // Reads zero

  // Values after reset
  // A divider of 1 gives an enable on every reference cycle
  localparam logic [DIV_W-1:0]    DIV_RESET    = DIV_W'(1);
  localparam logic [SETTLE_W-1:0] SETTLE_RESET = SETTLE_W'(16);

  // Enable pulses seen before a synchronized reset is released
  localparam int RST_SYNC_STAGES = 2;

endpackage

// ==== verilog/fll_cfg_regs.sv ====
// One ack per accepted req, one cycle later; a req held high is acked every other cycle
`timescale 1ns/1ps

module fll_cfg_regs
  import clk_rst_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic                  wrn_i,     // Low means write
  input  logic [CFG_ADDR_W-1:0] add_i,
  input  logic [CFG_DATA_W-1:0] data_i,
  input  logic                  lock_i,
  output logic                  ack_o,
  output logic [CFG_DATA_W-1:0] r_data_o,
  output logic [DIV_W-1:0]      div_o,
  output logic [SETTLE_W-1:0]   settle_o,
  output logic                  restart_o
);

  logic                  accept;
  logic                  wr_en;
  logic                  ack_q;
  logic                  restart_q;
  logic [DIV_W-1:0]      div_q;
  logic [SETTLE_W-1:0]   settle_q;
  logic [CFG_DATA_W-1:0] rd_mux;
  logic [CFG_DATA_W-1:0] r_data_q;

  // No new request is taken in the ack cycle itself
  assign accept = req_i & ~ack_q;
  assign wr_en  = accept & ~wrn_i;

  always_comb begin
    rd_mux = '0;
    case (add_i)
      ADDR_STATUS: rd_mux[0]              = lock_i;
      ADDR_DIV:    rd_mux[DIV_W-1:0]      = div_q;
      ADDR_SETTLE: rd_mux[SETTLE_W-1:0]   = settle_q;
      ADDR_SPARE:  rd_mux                 = '0;
      default:     rd_mux                 = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q     <= 1'b0;
      restart_q <= 1'b0;
    end else begin
      ack_q     <= accept;
      // Any change of divider or settle restarts the domain
      restart_q <= wr_en & ((add_i == ADDR_DIV) | (add_i == ADDR_SETTLE));
    end
  end

  // Settings land in the same edge that raises ack
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      div_q    <= DIV_RESET;
      settle_q <= SETTLE_RESET;
    end else if (wr_en) begin
      if (add_i == ADDR_DIV) begin
        div_q <= data_i[DIV_W-1:0];
      end
      if (add_i == ADDR_SETTLE) begin
        settle_q <= data_i[SETTLE_W-1:0];
      end
    end
  end

  // Read data only changes on accepted reads
  always_ff @(posedge clk) begin
    if (accept && wrn_i) begin
      r_data_q <= rd_mux;
    end
  end

  assign ack_o     = ack_q;
  assign r_data_o  = r_data_q;
  assign div_o     = div_q;
  assign settle_o  = settle_q;
  assign restart_o = restart_q;

endmodule

// ==== verilog/clk_en_div.sv ====
// Enable is a one-cycle pulse every max(div_i,1) clk cycles; div_i may only change with restart_i
`timescale 1ns/1ps

module clk_en_div
  import clk_rst_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic [DIV_W-1:0] div_i,
  input  logic             restart_i,
  input  logic             sel_ref_i,   // Bypass, enable on every cycle
  output logic             en_o
);

  logic [DIV_W-1:0] div_eff;
  logic [DIV_W-1:0] last_phase;
  logic [DIV_W-1:0] phase_q;
  logic             wrap;

  assign div_eff    = (div_i == '0) ? DIV_W'(1) : div_i;  // 0 counts as 1
  assign last_phase = div_eff - DIV_W'(1);

  // Greater-or-equal so a smaller divider never lets the phase run away
  assign wrap = (phase_q >= last_phase);

  always_ff @(posedge clk) begin
    if (!rst_n_i || restart_i) begin
      phase_q <= '0;
    end else if (wrap) begin
      phase_q <= '0;
    end else begin
      phase_q <= phase_q + DIV_W'(1);
    end
  end

  // First pulse lands div_eff cycles after the restart cycle
  assign en_o = sel_ref_i | (~restart_i & (phase_q == last_phase));

endmodule

// ==== verilog/fll_lock_mon.sv ====
// Lock goes high the cycle after the settle-th enable since restart; settle_i of 0 counts as 1
`timescale 1ns/1ps

module fll_lock_mon
  import clk_rst_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                en_i,
  input  logic                restart_i,
  input  logic [SETTLE_W-1:0] settle_i,
  output logic                lock_o
);

  logic [SETTLE_W-1:0] settle_eff;
  logic [SETTLE_W-1:0] pulse_cnt_q;
  logic                lock_q;
  logic                last_pulse;

  assign settle_eff = (settle_i == '0) ? SETTLE_W'(1) : settle_i;

  // This pulse is the settle-th one
  assign last_pulse = en_i & (pulse_cnt_q == settle_eff - SETTLE_W'(1));

  always_ff @(posedge clk) begin
    if (!rst_n_i || restart_i) begin
      pulse_cnt_q <= '0;
      lock_q      <= 1'b0;
    end else if (!lock_q && en_i) begin
      // Counting stops once locked
      pulse_cnt_q <= pulse_cnt_q + SETTLE_W'(1);
      if (last_pulse) begin
        lock_q <= 1'b1;
      end
    end
  end

  assign lock_o = lock_q;  // Held until next restart or reset

endmodule

// ==== verilog/rst_sync.sv ====
// Release follows the RST_SYNC_STAGES-th domain enable after rst_n_i rises; test mode is a bypass
`timescale 1ns/1ps

module rst_sync
  import clk_rst_pkg::*;
(
  input  logic clk,
  input  logic rst_n_i,
  input  logic en_i,
  input  logic test_mode_i,
  output logic rst_n_o
);

  logic [RST_SYNC_STAGES-1:0] sync_q;

  // Chain only moves on domain enables
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else if (en_i) begin
      sync_q <= {sync_q[RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  // Scan and test need the raw reset
  assign rst_n_o = test_mode_i ? rst_n_i : sync_q[RST_SYNC_STAGES-1];

endmodule

// ==== verilog/soc_clk_rst_gen.sv ====
// Domain clocks are enable pulses on clk, not gated clocks; per has no synchronized reset
`timescale 1ns/1ps

module soc_clk_rst_gen
  import clk_rst_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  test_mode_i,
  input  logic                  sel_fll_clk_i,   // Run every domain at reference rate

  input  logic                  soc_fll_slave_req_i,
  input  logic                  soc_fll_slave_wrn_i,
  input  logic [CFG_ADDR_W-1:0] soc_fll_slave_add_i,
  input  logic [CFG_DATA_W-1:0] soc_fll_slave_data_i,
  output logic                  soc_fll_slave_ack_o,
  output logic [CFG_DATA_W-1:0] soc_fll_slave_r_data_o,
  output logic                  soc_fll_slave_lock_o,

  input  logic                  per_fll_slave_req_i,
  input  logic                  per_fll_slave_wrn_i,
  input  logic [CFG_ADDR_W-1:0] per_fll_slave_add_i,
  input  logic [CFG_DATA_W-1:0] per_fll_slave_data_i,
  output logic                  per_fll_slave_ack_o,
  output logic [CFG_DATA_W-1:0] per_fll_slave_r_data_o,
  output logic                  per_fll_slave_lock_o,

  input  logic                  cluster_fll_slave_req_i,
  input  logic                  cluster_fll_slave_wrn_i,
  input  logic [CFG_ADDR_W-1:0] cluster_fll_slave_add_i,
  input  logic [CFG_DATA_W-1:0] cluster_fll_slave_data_i,
  output logic                  cluster_fll_slave_ack_o,
  output logic [CFG_DATA_W-1:0] cluster_fll_slave_r_data_o,
  output logic                  cluster_fll_slave_lock_o,

  output logic                  clk_soc_en_o,
  output logic                  clk_per_en_o,
  output logic                  clk_cluster_en_o,
  output logic                  rstn_soc_sync_o,
  output logic                  rstn_cluster_sync_o
);

  // Settings from each configuration slave
  logic [DIV_W-1:0]    soc_div;
  logic [DIV_W-1:0]    per_div;
  logic [DIV_W-1:0]    cluster_div;
  logic [SETTLE_W-1:0] soc_settle;
  logic [SETTLE_W-1:0] per_settle;
  logic [SETTLE_W-1:0] cluster_settle;
  logic                soc_restart;
  logic                per_restart;
  logic                cluster_restart;

  // Domain enables, also fed back to lock and reset logic
  logic                soc_en;
  logic                per_en;
  logic                cluster_en;

  logic                soc_lock;
  logic                per_lock;
  logic                cluster_lock;

  // soc domain
  fll_cfg_regs u_soc_cfg (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .req_i     (soc_fll_slave_req_i),
    .wrn_i     (soc_fll_slave_wrn_i),
    .add_i     (soc_fll_slave_add_i),
    .data_i    (soc_fll_slave_data_i),
    .lock_i    (soc_lock),
    .ack_o     (soc_fll_slave_ack_o),
    .r_data_o  (soc_fll_slave_r_data_o),
    .div_o     (soc_div),
    .settle_o  (soc_settle),
    .restart_o (soc_restart)
  );

  clk_en_div u_soc_div (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .div_i     (soc_div),
    .restart_i (soc_restart),
    .sel_ref_i (sel_fll_clk_i),
    .en_o      (soc_en)
  );

  fll_lock_mon u_soc_lock (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .en_i      (soc_en),
    .restart_i (soc_restart),
    .settle_i  (soc_settle),
    .lock_o    (soc_lock)
  );

  // per domain
  fll_cfg_regs u_per_cfg (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .req_i     (per_fll_slave_req_i),
    .wrn_i     (per_fll_slave_wrn_i),
    .add_i     (per_fll_slave_add_i),
    .data_i    (per_fll_slave_data_i),
    .lock_i    (per_lock),
    .ack_o     (per_fll_slave_ack_o),
    .r_data_o  (per_fll_slave_r_data_o),
    .div_o     (per_div),
    .settle_o  (per_settle),
    .restart_o (per_restart)
  );

  clk_en_div u_per_div (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .div_i     (per_div),
    .restart_i (per_restart),
    .sel_ref_i (sel_fll_clk_i),
    .en_o      (per_en)
  );

  fll_lock_mon u_per_lock (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .en_i      (per_en),
    .restart_i (per_restart),
    .settle_i  (per_settle),
    .lock_o    (per_lock)
  );

  // cluster domain
  fll_cfg_regs u_cluster_cfg (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .req_i     (cluster_fll_slave_req_i),
    .wrn_i     (cluster_fll_slave_wrn_i),
    .add_i     (cluster_fll_slave_add_i),
    .data_i    (cluster_fll_slave_data_i),
    .lock_i    (cluster_lock),
    .ack_o     (cluster_fll_slave_ack_o),
    .r_data_o  (cluster_fll_slave_r_data_o),
    .div_o     (cluster_div),
    .settle_o  (cluster_settle),
    .restart_o (cluster_restart)
  );

  clk_en_div u_cluster_div (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .div_i     (cluster_div),
    .restart_i (cluster_restart),
    .sel_ref_i (sel_fll_clk_i),
    .en_o      (cluster_en)
  );

  fll_lock_mon u_cluster_lock (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .en_i      (cluster_en),
    .restart_i (cluster_restart),
    .settle_i  (cluster_settle),
    .lock_o    (cluster_lock)
  );

  // Both synchronizers take the global reset, each paced by its own domain
  rst_sync u_soc_rst_sync (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .en_i        (soc_en),
    .test_mode_i (test_mode_i),
    .rst_n_o     (rstn_soc_sync_o)
  );

  rst_sync u_cluster_rst_sync (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .en_i        (cluster_en),
    .test_mode_i (test_mode_i),
    .rst_n_o     (rstn_cluster_sync_o)
  );

  assign soc_fll_slave_lock_o     = soc_lock;
  assign per_fll_slave_lock_o     = per_lock;
  assign cluster_fll_slave_lock_o = cluster_lock;

  assign clk_soc_en_o     = soc_en;
  assign clk_per_en_o     = per_en;
  assign clk_cluster_en_o = cluster_en;

endmodule

// ==== verif/tb_clk_gen.sv ====
// Free-running 20 ns clock; reset is held low over the first 4 rising edges and then stays high
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;  // 20 ns period
  end

  initial begin
    rst_n_o <= 1'b0;
    repeat (4) @(posedge clk_o);
    rst_n_o <= 1'b1;  // Released on the 4th rising edge
  end

endmodule

// ==== verif/tb_soc_clk_rst_gen.sv ====
// Inputs move on rising edges and outputs are sampled on falling edges; every wait ends after WAIT_LIMIT
`timescale 1ns/1ps

module tb_soc_clk_rst_gen
  import clk_rst_pkg::*;
();

  localparam int WAIT_LIMIT = 500;

  logic                  clk;
  logic                  gen_rst_n;
  logic                  tb_rst_n;     // Extra reset pulse for the test-mode check
  logic                  rst_n;
  logic                  test_mode;
  logic                  sel_fll;
  logic [2:0]            req;
  logic [2:0]            wrn;
  logic [CFG_ADDR_W-1:0] add [3];
  logic [CFG_DATA_W-1:0] wdata [3];
  wire  [2:0]            ack;
  wire  [2:0]            lock;
  wire  [2:0]            en;
  wire  [CFG_DATA_W-1:0] rdata [3];
  wire                   rstn_soc_sync;
  wire                   rstn_cluster_sync;

  // Reference model as plain integers, index 0 soc, 1 per, 2 cluster
  int          exp_div [3];
  int          exp_settle [3];
  logic [31:0] rng_state;
  int          errors;
  int          timeouts;
  string       dom_name [3];

  assign rst_n = gen_rst_n & tb_rst_n;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (gen_rst_n)
  );

  soc_clk_rst_gen u_dut (
    .clk                        (clk),
    .rst_n_i                    (rst_n),
    .test_mode_i                (test_mode),
    .sel_fll_clk_i              (sel_fll),
    .soc_fll_slave_req_i        (req[0]),
    .soc_fll_slave_wrn_i        (wrn[0]),
    .soc_fll_slave_add_i        (add[0]),
    .soc_fll_slave_data_i       (wdata[0]),
    .soc_fll_slave_ack_o        (ack[0]),
    .soc_fll_slave_r_data_o     (rdata[0]),
    .soc_fll_slave_lock_o       (lock[0]),
    .per_fll_slave_req_i        (req[1]),
    .per_fll_slave_wrn_i        (wrn[1]),
    .per_fll_slave_add_i        (add[1]),
    .per_fll_slave_data_i       (wdata[1]),
    .per_fll_slave_ack_o        (ack[1]),
    .per_fll_slave_r_data_o     (rdata[1]),
    .per_fll_slave_lock_o       (lock[1]),
    .cluster_fll_slave_req_i    (req[2]),
    .cluster_fll_slave_wrn_i    (wrn[2]),
    .cluster_fll_slave_add_i    (add[2]),
    .cluster_fll_slave_data_i   (wdata[2]),
    .cluster_fll_slave_ack_o    (ack[2]),
    .cluster_fll_slave_r_data_o (rdata[2]),
    .cluster_fll_slave_lock_o   (lock[2]),
    .clk_soc_en_o               (en[0]),
    .clk_per_en_o               (en[1]),
    .clk_cluster_en_o           (en[2]),
    .rstn_soc_sync_o            (rstn_soc_sync),
    .rstn_cluster_sync_o        (rstn_cluster_sync)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_small(input int range, output int val);
    rng_state = xorshift32(rng_state);
    val = int'(rng_state % 32'(range));
  endtask

  // 0..2 are the domain locks, 3 and 4 the synchronized resets
  function automatic logic watched_level(input int sig);
    if (sig < 3) begin
      return lock[sig];
    end
    return (sig == 3) ? rstn_soc_sync : rstn_cluster_sync;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // One req/ack exchange; lock_seen is the lock level the slave samples
  task automatic cfg_access(input int d, input logic wr_n, input logic [CFG_ADDR_W-1:0] a,
                            input logic [CFG_DATA_W-1:0] wd,
                            output logic [CFG_DATA_W-1:0] rd, output logic lock_seen);
    int waited;
    @(posedge clk);
    req[d]   <= 1'b1;
    wrn[d]   <= wr_n;
    add[d]   <= a;
    wdata[d] <= wd;
    @(negedge clk);
    lock_seen = lock[d];
    waited = 0;
    while (!ack[d] && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    rd = rdata[d];
    if (!ack[d]) begin
      timeouts++;
      $display("timeout: the %s slave never sent ack", dom_name[d]);
    end else begin
      compare_value({dom_name[d], " ack latency"}, 1, waited);
    end
    @(posedge clk);
    req[d] <= 1'b0;  // Dropped at the end of the ack cycle
  endtask

  task automatic write_reg(input int d, input logic [CFG_ADDR_W-1:0] a,
                           input logic [CFG_DATA_W-1:0] wd);
    logic [CFG_DATA_W-1:0] rd;
    logic                  lock_seen;
    cfg_access(d, 1'b0, a, wd, rd, lock_seen);
    if (a == ADDR_DIV) begin
      exp_div[d] = int'(wd[DIV_W-1:0]);
    end
    if (a == ADDR_SETTLE) begin
      exp_settle[d] = int'(wd[SETTLE_W-1:0]);
    end
  endtask

  task automatic read_check(input int d, input logic [CFG_ADDR_W-1:0] a);
    logic [CFG_DATA_W-1:0] rd;
    logic [CFG_DATA_W-1:0] expected;
    logic                  lock_seen;
    cfg_access(d, 1'b1, a, '0, rd, lock_seen);
    case (a)
      ADDR_DIV:    expected = 32'(exp_div[d]);
      ADDR_SETTLE: expected = 32'(exp_settle[d]);
      default:     expected = '0;
    endcase
    if (a == ADDR_STATUS) begin
      compare_value({dom_name[d], " status lock bit"}, 32'(lock_seen), 32'(rd[0]));
    end else begin
      compare_value($sformatf("%s read of address %0d", dom_name[d], a), expected, rd);
    end
  endtask

  // Gap counts falling edges up to and including the next enable
  task automatic wait_enable(input int d, output int gap);
    gap = 1;
    @(negedge clk);
    while (!en[d] && gap < WAIT_LIMIT) begin
      @(negedge clk);
      gap++;
    end
    if (!en[d]) begin
      timeouts++;
      $display("timeout: no enable pulse on the %s domain", dom_name[d]);
    end
  endtask

  task automatic check_period(input int d, input bit from_restart, input string name);
    int exp_gap;
    int gap;
    int k;
    exp_gap = (exp_div[d] == 0) ? 1 : exp_div[d];
    if (sel_fll) begin
      exp_gap = 1;
    end
    wait_enable(d, gap);
    if (from_restart) begin
      compare_value({name, " first pulse"}, exp_gap, gap);
    end
    for (k = 0; k < 3; k++) begin
      wait_enable(d, gap);
      compare_value({name, " gap"}, exp_gap, gap);
    end
  endtask

  // Starts on a falling edge; counts domain d enables until the watched signal is high
  task automatic check_rise(input int d, input int sig, input int target, input string name);
    int pulses;
    int waited;
    bit rose;
    pulses = 0;
    waited = 0;
    rose = 1'b0;
    while (!rose && waited < WAIT_LIMIT) begin
      if (watched_level(sig)) begin
        rose = 1'b1;
        compare_value({name, " enable pulses"}, target, pulses);
      end else begin
        if (en[d]) begin
          pulses++;
        end
        @(negedge clk);
        waited++;
      end
    end
    if (!rose) begin
      timeouts++;
      $display("timeout: %s never rose after %0d enable pulses", name, pulses);
    end
  endtask

  task automatic check_lock(input int d);
    int settle_eff;
    settle_eff = (exp_settle[d] == 0) ? 1 : exp_settle[d];
    @(negedge clk);
    compare_value({dom_name[d], " lock after restart"}, 0, 32'(lock[d]));
    check_rise(d, d, settle_eff, {dom_name[d], " lock"});
  endtask

  task automatic check_reset();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!rst_n && waited < WAIT_LIMIT) begin
      compare_value("acks in reset", 0, 32'(ack));
      compare_value("locks in reset", 0, 32'(lock));
      compare_value("synced resets in reset", 0, 32'({rstn_soc_sync, rstn_cluster_sync}));
      @(negedge clk);
      waited++;
    end
    if (!rst_n) begin
      timeouts++;
      $display("timeout: reset was never released");
    end
    fork
      check_rise(0, 3, RST_SYNC_STAGES, "soc synced reset");
      check_rise(2, 4, RST_SYNC_STAGES, "cluster synced reset");
    join
  endtask

  task automatic check_ref_select();
    int k;
    int val;
    @(posedge clk);
    sel_fll <= 1'b1;
    for (k = 0; k < 8; k++) begin
      @(negedge clk);
      compare_value("enables with reference select", 32'h7, 32'(en));
    end
    draw_small(8, val);
    write_reg(1, ADDR_SETTLE, {rng_state[31:SETTLE_W], SETTLE_W'(val)});
    check_lock(1);
    check_period(2, 1'b0, "cluster with reference select");
    @(posedge clk);
    sel_fll <= 1'b0;
  endtask

  task automatic check_test_mode();
    int k;
    @(posedge clk);
    test_mode <= 1'b1;
    for (k = 0; k < 10; k++) begin
      @(posedge clk);
      if (k == 2) begin
        tb_rst_n <= 1'b0;
      end
      if (k == 6) begin
        tb_rst_n <= 1'b1;
      end
      @(negedge clk);
      compare_value("soc reset in test mode", 32'(rst_n), 32'(rstn_soc_sync));
      compare_value("cluster reset in test mode", 32'(rst_n), 32'(rstn_cluster_sync));
    end
    // The pulse also reset every configuration slave
    for (k = 0; k < 3; k++) begin
      exp_div[k]    = int'(DIV_RESET);
      exp_settle[k] = int'(SETTLE_RESET);
      read_check(k, ADDR_DIV);
      read_check(k, ADDR_SETTLE);
    end
    @(posedge clk);
    test_mode <= 1'b0;
  endtask

  initial begin
    int d;
    int o;
    int k;
    int val;
    dom_name[0] = "soc";
    dom_name[1] = "per";
    dom_name[2] = "cluster";
    errors = 0;
    timeouts = 0;
    rng_state = 32'd91280;
    for (k = 0; k < 3; k++) begin
      exp_div[k]    = int'(DIV_RESET);
      exp_settle[k] = int'(SETTLE_RESET);
      add[k]       <= '0;
      wdata[k]     <= '0;
    end
    req       <= '0;
    wrn       <= '1;
    sel_fll   <= 1'b0;
    test_mode <= 1'b0;
    tb_rst_n  <= 1'b1;

    check_reset();
    for (d = 0; d < 3; d++) begin
      read_check(d, ADDR_STATUS);
      write_reg(d, ADDR_SPARE, rng_state);  // Spare ignores the write
      read_check(d, ADDR_SPARE);
      draw_small(5, val);  // Divider 0..4, zero behaves as 1
      write_reg(d, ADDR_DIV, {rng_state[31:DIV_W], DIV_W'(val)});
      check_period(d, 1'b1, $sformatf("%s divider %0d", dom_name[d], val));
      for (o = 0; o < 3; o++) begin
        if (o != d) begin
          check_period(o, 1'b0, $sformatf("%s untouched period", dom_name[o]));
        end
      end
      draw_small(8, val);
      write_reg(d, ADDR_SETTLE, {rng_state[31:SETTLE_W], SETTLE_W'(val)});
      check_lock(d);
      read_check(d, ADDR_DIV);
      read_check(d, ADDR_SETTLE);
      read_check(d, ADDR_STATUS);
    end
    check_ref_select();
    check_test_mode();

    $display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/clk_rst_pkg.sv
verilog/fll_cfg_regs.sv
verilog/clk_en_div.sv
verilog/fll_lock_mon.sv
verilog/rst_sync.sv
verilog/soc_clk_rst_gen.sv
verif/tb_clk_gen.sv
verif/tb_soc_clk_rst_gen.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the fail message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_soc_clk_rst_gen \
  -o tb_soc_clk_rst_gen

./obj_dir/tb_soc_clk_rst_gen > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
